/* logic/fetchPkg.sv */
// Shared types, RISC-V opcode constants and default sizes
// for the dual-issue fetch front end

package fetchPkg;

    // Meaningful widths
    typedef logic [31:0] addrT;
    typedef logic [31:0] instrT;
    typedef logic [6:0]  opcodeT;
    typedef logic [4:0]  regIdxT;

    // RV32I major opcodes
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_JALR   = 7'b1100111;
    localparam opcodeT OP_LUI    = 7'b0110111;
    localparam opcodeT OP_AUIPC  = 7'b0010111;
    localparam opcodeT OP_LOAD   = 7'b0000011;
    localparam opcodeT OP_STORE  = 7'b0100011;
    localparam opcodeT OP_OPIMM  = 7'b0010011;
    localparam opcodeT OP_OP     = 7'b0110011;

    // Fetch PC after reset
    localparam addrT PC_START = 32'h0000_0000;

    // Defaults for the module parameters
    localparam int DEF_BTB_ENTRIES = 32;
    localparam int DEF_GHR_BITS    = 5;
    localparam int DEF_CREDITS     = 4;

endpackage

/* logic/pairCheck.sv */
// Pair decoder: control flow in slot A and the
// RAW/WAW check that decides dual issue
`timescale 1ns/1ps

module pairCheck (
    input  fetchPkg::instrT instrA_i,
    input  fetchPkg::instrT instrB_i,
    output logic            controlFlowA_o,
    output logic            jumpA_o,
    output logic            branchA_o,
    output logic            dual_o
);
    import fetchPkg::*;

    opcodeT opA, opB;
    regIdxT rdA, rdB, rs1B, rs2B;
    logic   writeA, writeB;
    logic   controlFlowB;
    logic   raw, waw;

    // Opcodes that update a destination register
    function automatic logic writesReg(opcodeT op);
        case (op)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR: return 1'b1;
            OP_LOAD, OP_OPIMM, OP_OP:          return 1'b1;
            OP_STORE, OP_BRANCH:               return 1'b0;
            default:                           return 1'b0;
        endcase
    endfunction

    assign opA  = instrA_i[6:0];
    assign opB  = instrB_i[6:0];
    assign rdA  = instrA_i[11:7];
    assign rdB  = instrB_i[11:7];
    assign rs1B = instrB_i[19:15];
    assign rs2B = instrB_i[24:20];

    assign writeA = writesReg(opA);
    assign writeB = writesReg(opB);

    assign branchA_o      = (opA == OP_BRANCH);
    assign jumpA_o        = (opA == OP_JAL) || (opA == OP_JALR);
    assign controlFlowA_o = branchA_o || jumpA_o;
    assign controlFlowB   = (opB == OP_BRANCH) || (opB == OP_JAL) || (opB == OP_JALR);

    // rs2 compared regardless of format
    assign raw = writeA && (rdA != '0) && ((rdA == rs1B) || (rdA == rs2B));
    assign waw = writeA && writeB && (rdA != '0) && (rdA == rdB);

    assign dual_o = !(controlFlowA_o || controlFlowB || raw || waw);

endmodule

/* logic/branchTargetBuffer.sv */
// Untagged direct-mapped BTB holding a valid bit
// and a taken target per entry
`timescale 1ns/1ps

module branchTargetBuffer #(
    parameter int BtbEntries = fetchPkg::DEF_BTB_ENTRIES
) (
    input  logic           clk,
    input  logic           reset,
    input  fetchPkg::addrT lookupPc_i,
    output logic           hit_o,
    output fetchPkg::addrT target_o,
    input  logic           writeEn_i,
    input  fetchPkg::addrT writePc_i,
    input  fetchPkg::addrT writeTarget_i
);
    import fetchPkg::*;

    localparam int IdxBits = $clog2(BtbEntries);

    logic [BtbEntries-1:0] valid;
    addrT                  targets [BtbEntries];
    logic [IdxBits-1:0]    lookupIdx, writeIdx;

    // Word index, bits just above the byte offset
    assign lookupIdx = lookupPc_i[IdxBits+1:2];
    assign writeIdx  = writePc_i[IdxBits+1:2];

    assign hit_o    = valid[lookupIdx];
    assign target_o = targets[lookupIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (writeEn_i) begin
            valid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn_i) begin
            targets[writeIdx] <= writeTarget_i;
        end
    end

endmodule

/* logic/directionPredictor.sv */
// Global history register and pattern table
// of two-bit saturating counters
`timescale 1ns/1ps

module directionPredictor #(
    parameter int GhrBits = fetchPkg::DEF_GHR_BITS
) (
    input  logic               clk,
    input  logic               reset,
    output logic               taken_o,
    output logic [GhrBits-1:0] phtIndex_o,
    input  logic               shiftEn_i,
    input  logic               shiftBit_i,
    input  logic               historyClear_i,
    input  logic               updateEn_i,
    input  logic [GhrBits-1:0] updateIndex_i,
    input  logic               updateTaken_i
);

    localparam int PhtEntries = 2 ** GhrBits;

    logic [GhrBits-1:0] ghr;
    logic [1:0]         pht [PhtEntries];
    logic [1:0]         oldCount, newCount;

    // Lookup indexed by history alone
    assign phtIndex_o = ghr;
    assign taken_o    = pht[ghr][1];

    // Saturating step of the counter being trained
    assign oldCount = pht[updateIndex_i];
    always_comb begin
        newCount = oldCount;
        if (updateTaken_i && oldCount != 2'b11) begin
            newCount = oldCount + 2'b01;
        end else if (!updateTaken_i && oldCount != 2'b00) begin
            newCount = oldCount - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PhtEntries; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (updateEn_i) begin
            pht[updateIndex_i] <= newCount;
        end
    end

    // Clear wins over a shift
    always_ff @(posedge clk) begin
        if (reset || historyClear_i) begin
            ghr <= '0;
        end else if (shiftEn_i) begin
            ghr <= {ghr[GhrBits-2:0], shiftBit_i};
        end
    end

endmodule

/* logic/pcSequencer.sv */
// Fetch PC, next-PC selection, credit counter,
// bundle output registers and the mispredict flag
`timescale 1ns/1ps

module pcSequencer #(
    parameter int Credits = fetchPkg::DEF_CREDITS,
    parameter int GhrBits = fetchPkg::DEF_GHR_BITS
) (
    input  logic               clk,
    input  logic               reset,
    input  fetchPkg::instrT    instrA_i,
    input  fetchPkg::instrT    instrB_i,
    input  logic               controlFlowA_i,
    input  logic               jumpA_i,
    input  logic               branchA_i,
    input  logic               dual_i,
    input  logic               btbHit_i,
    input  fetchPkg::addrT     btbTarget_i,
    input  logic               dirTaken_i,
    input  logic [GhrBits-1:0] phtIndex_i,
    input  logic               creditReturn_i,
    input  logic               resolveValid_i,
    input  fetchPkg::addrT     resolvePc_i,
    input  logic               resolveTaken_i,
    input  fetchPkg::addrT     resolveTarget_i,
    input  logic               resolvePredTaken_i,
    output fetchPkg::addrT     fetchPc_o,
    output logic               accept_o,
    output logic               predTaken_o,
    output logic               mispredictNow_o,
    output logic               bundleValid_o,
    output fetchPkg::addrT     bundlePc_o,
    output fetchPkg::instrT    bundleInstrA_o,
    output fetchPkg::instrT    bundleInstrB_o,
    output logic               bundleDual_o,
    output logic               bundlePredTaken_o,
    output logic [GhrBits-1:0] bundlePhtIndex_o,
    output logic               mispredict_o
);
    import fetchPkg::*;

    localparam int CntBits = $clog2(Credits + 1);

    logic [CntBits-1:0] creditCount;
    logic               btbUse;
    addrT               nextPc;

    // BTB entry only counts when slot A redirects
    assign btbUse      = btbHit_i && controlFlowA_i;
    assign predTaken_o = btbUse && (jumpA_i || (branchA_i && dirTaken_i));

    assign mispredictNow_o = resolveValid_i && (resolveTaken_i != resolvePredTaken_i);
    assign accept_o        = (creditCount != '0) && !mispredictNow_o;

    // Redirect, then prediction, then sequential step
    always_comb begin
        if (mispredictNow_o) begin
            nextPc = resolveTaken_i ? resolveTarget_i : resolvePc_i + 32'd4;
        end else if (predTaken_o) begin
            nextPc = btbTarget_i;
        end else if (dual_i) begin
            nextPc = fetchPc_o + 32'd8;
        end else begin
            nextPc = fetchPc_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc_o <= PC_START;
        end else if (accept_o || mispredictNow_o) begin
            fetchPc_o <= nextPc;
        end
    end

    // Send and return may coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            creditCount <= CntBits'(Credits);
        end else begin
            case ({accept_o, creditReturn_i})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bundleValid_o <= 1'b0;
            mispredict_o  <= 1'b0;
        end else begin
            bundleValid_o <= accept_o;
            mispredict_o  <= mispredictNow_o;
        end
    end

    // Bundle payload
    always_ff @(posedge clk) begin
        if (accept_o) begin
            bundlePc_o        <= fetchPc_o;
            bundleInstrA_o    <= instrA_i;
            bundleInstrB_o    <= instrB_i;
            bundleDual_o      <= dual_i;
            bundlePredTaken_o <= predTaken_o;
            bundlePhtIndex_o  <= phtIndex_i;
        end
    end

endmodule

/* logic/dualFetch.sv */
// Dual-issue fetch front end: pair check, BTB,
// direction predictor and PC sequencer
`timescale 1ns/1ps

module dualFetch #(
    parameter int BtbEntries = fetchPkg::DEF_BTB_ENTRIES,
    parameter int GhrBits    = fetchPkg::DEF_GHR_BITS,
    parameter int Credits    = fetchPkg::DEF_CREDITS
) (
    input  logic               clk,
    input  logic               reset,
    // Instruction memory
    output fetchPkg::addrT     fetchPc_o,
    input  fetchPkg::instrT    instrA_i,
    input  fetchPkg::instrT    instrB_i,
    // Bundle to decode
    output logic               bundleValid_o,
    output fetchPkg::addrT     bundlePc_o,
    output fetchPkg::instrT    bundleInstrA_o,
    output fetchPkg::instrT    bundleInstrB_o,
    output logic               bundleDual_o,
    output logic               predTaken_o,
    output logic [GhrBits-1:0] phtIndex_o,
    input  logic               creditReturn_i,
    // Resolve from execute
    input  logic               resolveValid_i,
    input  fetchPkg::addrT     resolvePc_i,
    input  logic               resolveBranch_i,
    input  logic               resolveTaken_i,
    input  fetchPkg::addrT     resolveTarget_i,
    input  logic               resolvePredTaken_i,
    input  logic [GhrBits-1:0] resolvePhtIndex_i,
    output logic               mispredict_o
);
    import fetchPkg::*;

    logic               controlFlowA, jumpA, branchA, dual;
    logic               btbHit, dirTaken;
    addrT               btbTarget;
    logic [GhrBits-1:0] lookupIndex;
    logic               accept, fetchPredTaken, mispredictNow;

    pairCheck i_pairCheck (
        .instrA_i       (instrA_i),
        .instrB_i       (instrB_i),
        .controlFlowA_o (controlFlowA),
        .jumpA_o        (jumpA),
        .branchA_o      (branchA),
        .dual_o         (dual)
    );

    // Only taken outcomes allocate
    branchTargetBuffer #(
        .BtbEntries (BtbEntries)
    ) i_btb (
        .clk           (clk),
        .reset         (reset),
        .lookupPc_i    (fetchPc_o),
        .hit_o         (btbHit),
        .target_o      (btbTarget),
        .writeEn_i     (resolveValid_i && resolveTaken_i),
        .writePc_i     (resolvePc_i),
        .writeTarget_i (resolveTarget_i)
    );

    directionPredictor #(
        .GhrBits (GhrBits)
    ) i_dirPred (
        .clk            (clk),
        .reset          (reset),
        .taken_o        (dirTaken),
        .phtIndex_o     (lookupIndex),
        .shiftEn_i      (accept && branchA),
        .shiftBit_i     (fetchPredTaken),
        .historyClear_i (mispredictNow),
        .updateEn_i     (resolveValid_i && resolveBranch_i),
        .updateIndex_i  (resolvePhtIndex_i),
        .updateTaken_i  (resolveTaken_i)
    );

    pcSequencer #(
        .Credits (Credits),
        .GhrBits (GhrBits)
    ) i_pcSeq (
        .clk                (clk),
        .reset              (reset),
        .instrA_i           (instrA_i),
        .instrB_i           (instrB_i),
        .controlFlowA_i     (controlFlowA),
        .jumpA_i            (jumpA),
        .branchA_i          (branchA),
        .dual_i             (dual),
        .btbHit_i           (btbHit),
        .btbTarget_i        (btbTarget),
        .dirTaken_i         (dirTaken),
        .phtIndex_i         (lookupIndex),
        .creditReturn_i     (creditReturn_i),
        .resolveValid_i     (resolveValid_i),
        .resolvePc_i        (resolvePc_i),
        .resolveTaken_i     (resolveTaken_i),
        .resolveTarget_i    (resolveTarget_i),
        .resolvePredTaken_i (resolvePredTaken_i),
        .fetchPc_o          (fetchPc_o),
        .accept_o           (accept),
        .predTaken_o        (fetchPredTaken),
        .mispredictNow_o    (mispredictNow),
        .bundleValid_o      (bundleValid_o),
        .bundlePc_o         (bundlePc_o),
        .bundleInstrA_o     (bundleInstrA_o),
        .bundleInstrB_o     (bundleInstrB_o),
        .bundleDual_o       (bundleDual_o),
        .bundlePredTaken_o  (predTaken_o),
        .bundlePhtIndex_o   (phtIndex_o),
        .mispredict_o       (mispredict_o)
    );

endmodule

/* tests/fetchChecker.sv */
// Reference model of the fetch front end, compared
// cycle by cycle against the DUT outputs
`timescale 1ns/1ps

module fetchChecker #(
    parameter int BtbEntries = fetchPkg::DEF_BTB_ENTRIES,
    parameter int GhrBits    = fetchPkg::DEF_GHR_BITS,
    parameter int Credits    = fetchPkg::DEF_CREDITS
) (
    input  logic               clk,
    input  logic               reset,
    input  fetchPkg::addrT     fetchPc_i,
    input  fetchPkg::instrT    instrA_i,
    input  fetchPkg::instrT    instrB_i,
    input  logic               bundleValid_i,
    input  fetchPkg::addrT     bundlePc_i,
    input  fetchPkg::instrT    bundleInstrA_i,
    input  fetchPkg::instrT    bundleInstrB_i,
    input  logic               bundleDual_i,
    input  logic               predTaken_i,
    input  logic [GhrBits-1:0] phtIndex_i,
    input  logic               creditReturn_i,
    input  logic               resolveValid_i,
    input  fetchPkg::addrT     resolvePc_i,
    input  logic               resolveBranch_i,
    input  logic               resolveTaken_i,
    input  fetchPkg::addrT     resolveTarget_i,
    input  logic               resolvePredTaken_i,
    input  logic [GhrBits-1:0] resolvePhtIndex_i,
    input  logic               mispredict_i,
    output int                 errorCount_o,
    output int                 bundleCount_o,
    output int                 dualCount_o,
    output int                 predTakenCount_o,
    output int                 mispredictCount_o
);
    import fetchPkg::*;

    // Model state
    addrT               mPc;
    int                 mCredits;
    logic               mValid, mDual, mPredTaken, mMispredict;
    addrT               mBundlePc;
    instrT              mInstrA, mInstrB;
    logic [GhrBits-1:0] mGhr, mPhtIndex;
    logic [BtbEntries-1:0] btbValid;
    addrT               btbTarget [BtbEntries];
    logic [1:0]         pht [2**GhrBits];

    initial begin
        errorCount_o      = 0;
        bundleCount_o     = 0;
        dualCount_o       = 0;
        predTakenCount_o  = 0;
        mispredictCount_o = 0;
    end

    function automatic logic isWriter(opcodeT op);
        return op == OP_LUI || op == OP_AUIPC || op == OP_JAL || op == OP_JALR ||
               op == OP_LOAD || op == OP_OPIMM || op == OP_OP;
    endfunction

    function automatic logic isControl(opcodeT op);
        return op == OP_BRANCH || op == OP_JAL || op == OP_JALR;
    endfunction

    task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
            errorCount_o++;
        end
    endtask

    task automatic resetModel();
        mPc         = PC_START;
        mCredits    = Credits;
        mValid      = 1'b0;
        mMispredict = 1'b0;
        mGhr        = '0;
        btbValid    = '0;
        for (int i = 0; i < 2**GhrBits; i++) begin
            pht[i] = 2'b01;
        end
    endtask

    task automatic compareOutputs();
        compareValue("fetchPc_o", fetchPc_i, mPc);
        compareValue("bundleValid_o", 32'(bundleValid_i), 32'(mValid));
        compareValue("mispredict_o", 32'(mispredict_i), 32'(mMispredict));
        if (mValid) begin
            compareValue("bundlePc_o", bundlePc_i, mBundlePc);
            compareValue("bundleInstrA_o", bundleInstrA_i, mInstrA);
            compareValue("bundleInstrB_o", bundleInstrB_i, mInstrB);
            compareValue("bundleDual_o", 32'(bundleDual_i), 32'(mDual));
            compareValue("predTaken_o", 32'(predTaken_i), 32'(mPredTaken));
            compareValue("phtIndex_o", 32'(phtIndex_i), 32'(mPhtIndex));
        end
        // Counts follow what the DUT actually delivered
        if (bundleValid_i === 1'b1) begin
            bundleCount_o++;
            dualCount_o      += (bundleDual_i === 1'b1);
            predTakenCount_o += (predTaken_i === 1'b1);
        end
        mispredictCount_o += (mispredict_i === 1'b1);
    endtask

    task automatic stepModel();
        opcodeT opA, opB;
        logic   brA, jA, raw, waw, dual, hit, predT, misNow, acc;
        int     idx;
        addrT   nextPc;
        opA = instrA_i[6:0];
        opB = instrB_i[6:0];
        brA = opA == OP_BRANCH;
        jA  = opA == OP_JAL || opA == OP_JALR;
        raw = isWriter(opA) && instrA_i[11:7] != 0 &&
              (instrA_i[11:7] == instrB_i[19:15] || instrA_i[11:7] == instrB_i[24:20]);
        waw = isWriter(opA) && isWriter(opB) && instrA_i[11:7] != 0 &&
              instrA_i[11:7] == instrB_i[11:7];
        dual = !(isControl(opA) || isControl(opB) || raw || waw);
        idx    = (mPc >> 2) % BtbEntries;
        hit    = btbValid[idx];
        predT  = hit && (jA || (brA && pht[mGhr][1]));
        misNow = resolveValid_i && (resolveTaken_i != resolvePredTaken_i);
        acc    = mCredits != 0 && !misNow;
        if (misNow) begin
            nextPc = resolveTaken_i ? resolveTarget_i : resolvePc_i + 4;
        end else if (predT) begin
            nextPc = btbTarget[idx];
        end else begin
            nextPc = dual ? mPc + 8 : mPc + 4;
        end
        // Bundle registers see the old history
        if (acc) begin
            mBundlePc  = mPc;
            mInstrA    = instrA_i;
            mInstrB    = instrB_i;
            mDual      = dual;
            mPredTaken = predT;
            mPhtIndex  = mGhr;
        end
        if (resolveValid_i && resolveBranch_i) begin
            if (resolveTaken_i && pht[resolvePhtIndex_i] != 2'b11) begin
                pht[resolvePhtIndex_i]++;
            end else if (!resolveTaken_i && pht[resolvePhtIndex_i] != 2'b00) begin
                pht[resolvePhtIndex_i]--;
            end
        end
        if (resolveValid_i && resolveTaken_i) begin
            btbValid[(resolvePc_i >> 2) % BtbEntries]  = 1'b1;
            btbTarget[(resolvePc_i >> 2) % BtbEntries] = resolveTarget_i;
        end
        if (misNow) begin
            mGhr = '0;
        end else if (acc && brA) begin
            mGhr = {mGhr[GhrBits-2:0], predT};
        end
        mCredits    = mCredits - acc + creditReturn_i;
        mValid      = acc;
        mMispredict = misNow;
        if (acc || misNow) begin
            mPc = nextPc;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            resetModel();
        end else begin
            compareOutputs();
            stepModel();
        end
    end

endmodule

/* tests/dualFetchTb.sv */
// Testbench for the dual-issue fetch front end: clock, reset,
// random program memory, credit return and resolve driver
`timescale 1ns/1ps

module dualFetchTb;
    import fetchPkg::*;

    localparam int BtbEntries = DEF_BTB_ENTRIES;
    localparam int GhrBits    = DEF_GHR_BITS;
    localparam int Credits    = DEF_CREDITS;
    localparam int MemWords   = 256;

    typedef struct packed {
        int unsigned        due;
        addrT               pc;
        logic               branch;
        logic               taken;
        addrT               target;
        logic               predTaken;
        logic [GhrBits-1:0] pht;
    } resolveT;

    logic clk, reset;
    addrT fetchPc_o, bundlePc_o, resolvePc_i, resolveTarget_i;
    instrT instrA_i, instrB_i, bundleInstrA_o, bundleInstrB_o;
    logic bundleValid_o, bundleDual_o, predTaken_o, mispredict_o, creditReturn_i;
    logic resolveValid_i, resolveBranch_i, resolveTaken_i, resolvePredTaken_i;
    logic [GhrBits-1:0] phtIndex_o, resolvePhtIndex_i;
    int errorCount, bundleCount, dualCount, predTakenCount, mispredictCount;

    instrT       prog [MemWords];
    resolveT     pending [$];
    int unsigned cycleNum;
    int          outstanding, testsRun, testsFailed;
    logic        autoCredit, autoResolve;

    dualFetch #(.BtbEntries(BtbEntries), .GhrBits(GhrBits), .Credits(Credits)) i_dut (.*);

    fetchChecker #(.BtbEntries(BtbEntries), .GhrBits(GhrBits), .Credits(Credits)) i_checker (
        .clk(clk), .reset(reset), .fetchPc_i(fetchPc_o), .instrA_i(instrA_i),
        .instrB_i(instrB_i), .bundleValid_i(bundleValid_o), .bundlePc_i(bundlePc_o),
        .bundleInstrA_i(bundleInstrA_o), .bundleInstrB_i(bundleInstrB_o),
        .bundleDual_i(bundleDual_o), .predTaken_i(predTaken_o), .phtIndex_i(phtIndex_o),
        .creditReturn_i(creditReturn_i), .resolveValid_i(resolveValid_i),
        .resolvePc_i(resolvePc_i), .resolveBranch_i(resolveBranch_i),
        .resolveTaken_i(resolveTaken_i), .resolveTarget_i(resolveTarget_i),
        .resolvePredTaken_i(resolvePredTaken_i), .resolvePhtIndex_i(resolvePhtIndex_i),
        .mispredict_i(mispredict_o), .errorCount_o(errorCount), .bundleCount_o(bundleCount),
        .dualCount_o(dualCount), .predTakenCount_o(predTakenCount),
        .mispredictCount_o(mispredictCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Global watchdog behind the per-wait timeouts
    initial begin
        #400000;
        $display("Timeout: the run did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic instrT randomWord(logic hazardFree, int slot);
        int    pick;
        instrT w;
        pick = $urandom % 16;
        if (hazardFree) begin
            w = {7'b0, 5'(8 + $urandom % 4), 5'(8 + $urandom % 4), 3'b0,
                 5'((slot % 2) ? 4 + $urandom % 3 : 1 + $urandom % 3), OP_OP};
        end else if (pick < 10) begin
            w = {7'b0, 5'($urandom % 6), 5'($urandom % 6), 3'($urandom), 5'($urandom % 6),
                 (pick % 2) ? OP_OP : OP_OPIMM};
        end else if (pick < 13) begin
            w = {25'($urandom), OP_BRANCH};
        end else if (pick < 15) begin
            w = {20'($urandom), 5'($urandom % 6), OP_JAL};
        end else begin
            w = {20'($urandom), 5'($urandom % 6), OP_JALR};
        end
        return w;
    endfunction

    task automatic loadProgram(logic hazardFree);
        for (int i = 0; i < MemWords; i++) begin
            prog[i] = randomWord(hazardFree, i);
        end
    endtask

    task automatic cycle();
        opcodeT  op;
        resolveT r;
        @(posedge clk);
        #1;
        cycleNum++;
        instrA_i       = prog[(fetchPc_o >> 2) % MemWords];
        instrB_i       = prog[((fetchPc_o >> 2) + 1) % MemWords];
        creditReturn_i = 1'b0;
        resolveValid_i = 1'b0;
        if (!reset) begin
            op = bundleInstrA_o[6:0];
            if (bundleValid_o) begin
                outstanding++;
                if (autoResolve && (op == OP_BRANCH || op == OP_JAL || op == OP_JALR)) begin
                    r.due       = cycleNum + 2 + $urandom % 5;
                    r.pc        = bundlePc_o;
                    r.branch    = op == OP_BRANCH;
                    r.taken     = r.branch ? 1'($urandom) : 1'b1;
                    r.target    = $urandom & 32'h0000_03FC;
                    r.predTaken = predTaken_o;
                    r.pht       = phtIndex_o;
                    pending.push_back(r);
                end
            end
            if (autoCredit && outstanding > 0 && $urandom % 3 != 0) begin
                creditReturn_i = 1'b1;
                outstanding--;
            end
            foreach (pending[i]) begin
                if (!resolveValid_i && pending[i].due <= cycleNum) begin
                    driveResolve(pending[i].pc, pending[i].branch, pending[i].taken,
                                 pending[i].target, pending[i].predTaken, pending[i].pht);
                    pending.delete(i);
                    break;
                end
            end
        end
    endtask

    task automatic driveResolve(addrT pc, logic branch, logic taken, addrT target,
                                logic predTaken, logic [GhrBits-1:0] pht);
        resolveValid_i     = 1'b1;
        resolvePc_i        = pc;
        resolveBranch_i    = branch;
        resolveTaken_i     = taken;
        resolveTarget_i    = target;
        resolvePredTaken_i = predTaken;
        resolvePhtIndex_i  = pht;
    endtask

    task automatic applyReset();
        reset = 1'b1;
        pending.delete();
        repeat (8) cycle();
        outstanding = 0;
        reset = 1'b0;
    endtask

    task automatic finishTest(string name, int errorsBefore, logic ok);
        testsRun++;
        if (ok && errorCount == errorsBefore) begin
            $display("[test %0d] %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("[test %0d] %s: failed", testsRun, name);
        end
    endtask

    initial begin
        int   errs, bundles, singles, mis, waitCount;
        logic ok;
        void'($urandom(5573));
        reset = 1'b1;
        creditReturn_i = 1'b0;
        resolveValid_i = 1'b0;
        resolvePc_i = '0;
        resolveBranch_i = 1'b0;
        resolveTaken_i = 1'b0;
        resolveTarget_i = '0;
        resolvePredTaken_i = 1'b0;
        resolvePhtIndex_i = '0;
        instrA_i = '0;
        instrB_i = '0;
        cycleNum = 0;
        testsRun = 0;
        testsFailed = 0;

        // Hazard-free stream issues only dual bundles
        autoCredit = 1'b1;
        autoResolve = 1'b0;
        loadProgram(1'b1);
        applyReset();
        errs = errorCount;
        bundles = bundleCount;
        singles = bundleCount - dualCount;
        repeat (200) cycle();
        ok = bundleCount > bundles && (bundleCount - dualCount) == singles;
        finishTest("reset state and dual stream", errs, ok);

        // Hazards and control flow force single issue
        autoResolve = 1'b1;
        loadProgram(1'b0);
        applyReset();
        errs = errorCount;
        singles = bundleCount - dualCount;
        repeat (600) cycle();
        finishTest("RAW, WAW and control-flow pairs", errs, (bundleCount - dualCount) > singles);

        // Trained predictor gives taken predictions
        errs = errorCount;
        bundles = predTakenCount;
        repeat (3000) cycle();
        finishTest("BTB and history prediction", errs, predTakenCount > bundles);

        // Withheld credits stall delivery
        autoCredit = 1'b0;
        autoResolve = 1'b0;
        loadProgram(1'b1);
        applyReset();
        errs = errorCount;
        bundles = bundleCount;
        repeat (40) cycle();
        ok = (bundleCount - bundles) == Credits && !bundleValid_o;
        if (!ok) begin
            $display("Credit stall delivered %0d bundles instead of %0d",
                     bundleCount - bundles, Credits);
        end
        autoCredit = 1'b1;
        bundles = bundleCount;
        waitCount = 0;
        while (bundleCount == bundles && waitCount < 50) begin
            cycle();
            waitCount++;
        end
        if (bundleCount == bundles) begin
            $display("Delivery did not restart after credits resumed");
            ok = 1'b0;
        end
        finishTest("credit back-pressure", errs, ok);

        // Directed resolves, two mismatched and one matching
        applyReset();
        errs = errorCount;
        mis = mispredictCount;
        repeat (10) cycle();
        driveResolve(32'h40, 1'b1, 1'b1, 32'h100, 1'b0, '0);
        repeat (6) cycle();
        driveResolve(32'h80, 1'b1, 1'b0, 32'h200, 1'b1, '0);
        repeat (6) cycle();
        driveResolve(32'hC0, 1'b0, 1'b1, 32'h300, 1'b1, '0);
        waitCount = 0;
        while (mispredictCount - mis < 2 && waitCount < 20) begin
            cycle();
            waitCount++;
        end
        repeat (6) cycle();
        ok = (mispredictCount - mis) == 2;
        if (!ok) begin
            $display("Expected 2 mispredicts, saw %0d", mispredictCount - mis);
        end
        finishTest("mispredict recovery", errs, ok);

        $display("Tests run %0d, failed %0d, value errors %0d, bundles checked %0d",
                 testsRun, testsFailed, errorCount, bundleCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* dualFetch.f */
logic/fetchPkg.sv
logic/pairCheck.sv
logic/branchTargetBuffer.sv
logic/directionPredictor.sv
logic/pcSequencer.sv
logic/dualFetch.sv
tests/fetchChecker.sv
tests/dualFetchTb.sv

/* Bender.yml */
package:
  name: dualFetch

sources:
  - files:
      - logic/fetchPkg.sv
      - logic/pairCheck.sv
      - logic/branchTargetBuffer.sv
      - logic/directionPredictor.sv
      - logic/pcSequencer.sv
      - logic/dualFetch.sv
  - target: test
    files:
      - tests/fetchChecker.sv
      - tests/dualFetchTb.sv
